/* hdl/bus_monitor.sv */
// Bus monitor: classifies START, STOP and SCL edges from the synchronized bus lines
`timescale 1ns/1ps

module bus_monitor (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   scl_i,
  input  logic                   sda_i,
  output i3c_pkg::bus_event_t    event_o
);

  logic scl_q;
  logic sda_q;
  logic start_det;
  logic stop_det;

  // SDA may only move while SCL is high for START and STOP
  assign start_det = scl_q && scl_i && sda_q && !sda_i;
  assign stop_det  = scl_q && scl_i && !sda_q && sda_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      scl_q   <= 1'b1;
      sda_q   <= 1'b1;
      event_o <= '{start: 1'b0, stop: 1'b0, scl_rise: 1'b0, scl_fall: 1'b0, sda: 1'b1};
    end else begin
      scl_q            <= scl_i;
      sda_q            <= sda_i;
      event_o.start    <= start_det;
      event_o.stop     <= stop_det;
      event_o.scl_rise <= !scl_q && scl_i;
      event_o.scl_fall <= scl_q && !scl_i;
      // Level seen at the rising edge is the sampled bit
      event_o.sda      <= sda_i;
    end
  end

  // Both lines moving in one cycle cannot be classified
  one_line_change_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !((scl_q != scl_i) && (sda_q != sda_i))
  );

endmodule

/* hdl/csr_regs.sv */
// CPU register block: target address, queue status and RX data/descriptor pop windows
`timescale 1ns/1ps
`include "i3c_settings.svh"

module csr_regs (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  i3c_pkg::cpuif_req_t                       req_i,
  input  i3c_pkg::rx_data_t                         data_head_i,
  input  i3c_pkg::rx_desc_t                         desc_head_i,
  input  logic                                      data_empty_i,
  input  logic                                      desc_empty_i,
  input  logic [$clog2(`I3C_RX_DATA_DEPTH+1)-1:0]   data_count_i,
  input  logic [$clog2(`I3C_RX_DESC_DEPTH+1)-1:0]   desc_count_i,
  output i3c_pkg::cpuif_rsp_t                       rsp_o,
  output logic [6:0]                                target_addr_o,
  output logic                                      data_pop_o,
  output logic                                      desc_pop_o
);

  localparam int unsigned AW = `I3C_CSR_AW;
  localparam int unsigned DW = `I3C_CSR_DW;

  localparam logic [AW-1:0] REG_TARGET_ADDR = `I3C_REG_TARGET_ADDR;
  localparam logic [AW-1:0] REG_STATUS      = `I3C_REG_STATUS;
  localparam logic [AW-1:0] REG_RX_DESC     = `I3C_REG_RX_DESC;
  localparam logic [AW-1:0] REG_RX_DATA     = `I3C_REG_RX_DATA;

  logic [6:0]    target_addr_q;
  logic          rd_ack_q;
  logic          wr_ack_q;
  logic [DW-1:0] rd_data_q;
  logic [DW-1:0] rd_mux;
  logic          rd_req;
  logic          wr_req;

  assign rd_req = req_i.req && !req_i.is_wr;
  assign wr_req = req_i.req && req_i.is_wr;

  // Queue reads pop in the request cycle, head is captured alongside
  assign data_pop_o = rd_req && (req_i.addr == REG_RX_DATA) && !data_empty_i;
  assign desc_pop_o = rd_req && (req_i.addr == REG_RX_DESC) && !desc_empty_i;

  always_comb begin
    rd_mux = '0;
    case (req_i.addr)
      REG_TARGET_ADDR: rd_mux[6:0] = target_addr_q;
      REG_STATUS: begin
        rd_mux[3:0]  = 4'(data_count_i);
        rd_mux[11:8] = 4'(desc_count_i);
      end
      REG_RX_DESC: begin
        if (!desc_empty_i) begin
          rd_mux[DW-1] = 1'b1;
          rd_mux[15:0] = desc_head_i;
        end
      end
      REG_RX_DATA: begin
        if (!data_empty_i) begin
          rd_mux[DW-1] = 1'b1;
          rd_mux[7:0]  = data_head_i;
        end
      end
      default: rd_mux = '0;
    endcase
  end

  // Only the address register is writable, other offsets just ack
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      target_addr_q <= `I3C_TARGET_ADDR_RST;
      rd_ack_q      <= 1'b0;
      wr_ack_q      <= 1'b0;
    end else begin
      rd_ack_q <= rd_req;
      wr_ack_q <= wr_req;
      if (wr_req && req_i.addr == REG_TARGET_ADDR) begin
        target_addr_q <= req_i.wr_data[6:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      rd_data_q <= rd_mux;
    end
  end

  assign rsp_o         = '{rd_ack: rd_ack_q, wr_ack: wr_ack_q, rd_data: rd_data_q};
  assign target_addr_o = target_addr_q;

endmodule

/* hdl/i3c_phy.sv */
// I3C PHY: synchronizes SCL/SDA from the bus and registers the open-drain SDA output
`timescale 1ns/1ps

module i3c_phy (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic scl_i,
  input  logic sda_i,
  input  logic sda_drive_i,
  output logic scl_sync_o,
  output logic sda_sync_o,
  output logic scl_o,
  output logic sda_o
);

  logic [1:0] scl_sync_q;
  logic [1:0] sda_sync_q;
  logic       sda_out_q;

  // Idle bus is high, so both stages come out of reset released
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      scl_sync_q <= 2'b11;
      sda_sync_q <= 2'b11;
      sda_out_q  <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[0], scl_i};
      sda_sync_q <= {sda_sync_q[0], sda_i};
      sda_out_q  <= sda_drive_i;
    end
  end

  assign scl_sync_o = scl_sync_q[1];
  assign sda_sync_o = sda_sync_q[1];
  assign sda_o      = sda_out_q;

  // Target never stretches the clock
  assign scl_o = 1'b1;

endmodule

/* hdl/i3c_pkg.sv */
// I3C target shared types: CPU request/response, bus events and receive queue entries
`include "i3c_settings.svh"

package i3c_pkg;

  // One CPU access, req is a single-cycle strobe
  typedef struct packed {
    logic                   req;
    logic                   is_wr;
    logic [`I3C_CSR_AW-1:0] addr;
    logic [`I3C_CSR_DW-1:0] wr_data;
  } cpuif_req_t;

  // Answer to a CPU access, one cycle after req
  typedef struct packed {
    logic                   rd_ack;
    logic                   wr_ack;
    logic [`I3C_CSR_DW-1:0] rd_data;
  } cpuif_rsp_t;

  // Decoded bus activity for one clock cycle
  typedef struct packed {
    logic start;
    logic stop;
    logic scl_rise;
    logic scl_fall;
    logic sda;
  } bus_event_t;

  // One received data byte
  typedef logic [7:0] rx_data_t;

  // Summary of one completed write transfer
  typedef struct packed {
    logic [6:0] addr;
    logic       rnw;
    logic [7:0] byte_count;
  } rx_desc_t;

endpackage

/* hdl/i3c_target.sv */
// I3C target receive path top: PHY, bus monitor, receive FSM, RX queues and CPU registers
`timescale 1ns/1ps
`include "i3c_settings.svh"

module i3c_target (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                i3c_scl_i,
  input  logic                i3c_sda_i,
  output logic                i3c_scl_o,
  output logic                i3c_sda_o,
  input  i3c_pkg::cpuif_req_t cpu_req_i,
  output i3c_pkg::cpuif_rsp_t cpu_rsp_o
);

  import i3c_pkg::*;

  localparam int unsigned DATA_CNT_W = $clog2(`I3C_RX_DATA_DEPTH + 1);
  localparam int unsigned DESC_CNT_W = $clog2(`I3C_RX_DESC_DEPTH + 1);

  logic                  scl_sync;
  logic                  sda_sync;
  logic                  sda_drive;
  bus_event_t            bus_event;
  logic [6:0]            target_addr;

  // RX data queue
  logic                  data_push;
  rx_data_t              data_wr;
  logic                  data_pop;
  rx_data_t              data_head;
  logic                  data_empty;
  logic                  data_full;
  logic [DATA_CNT_W-1:0] data_count;

  // RX descriptor queue
  logic                  desc_push;
  rx_desc_t              desc_wr;
  logic                  desc_pop;
  rx_desc_t              desc_head;
  logic                  desc_empty;
  logic                  desc_full;
  logic [DESC_CNT_W-1:0] desc_count;

  i3c_phy u_phy (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .scl_i       (i3c_scl_i),
    .sda_i       (i3c_sda_i),
    .sda_drive_i (sda_drive),
    .scl_sync_o  (scl_sync),
    .sda_sync_o  (sda_sync),
    .scl_o       (i3c_scl_o),
    .sda_o       (i3c_sda_o)
  );

  bus_monitor u_bus_monitor (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .scl_i   (scl_sync),
    .sda_i   (sda_sync),
    .event_o (bus_event)
  );

  target_rx_fsm u_rx_fsm (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .event_i       (bus_event),
    .target_addr_i (target_addr),
    .data_full_i   (data_full),
    .desc_full_i   (desc_full),
    .sda_drive_o   (sda_drive),
    .data_push_o   (data_push),
    .data_o        (data_wr),
    .desc_push_o   (desc_push),
    .desc_o        (desc_wr)
  );

  sync_fifo #(
    .payload_t (rx_data_t),
    .DEPTH     (`I3C_RX_DATA_DEPTH)
  ) u_rx_data_q (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (data_push),
    .data_i  (data_wr),
    .pop_i   (data_pop),
    .head_o  (data_head),
    .empty_o (data_empty),
    .full_o  (data_full),
    .count_o (data_count)
  );

  sync_fifo #(
    .payload_t (rx_desc_t),
    .DEPTH     (`I3C_RX_DESC_DEPTH)
  ) u_rx_desc_q (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (desc_push),
    .data_i  (desc_wr),
    .pop_i   (desc_pop),
    .head_o  (desc_head),
    .empty_o (desc_empty),
    .full_o  (desc_full),
    .count_o (desc_count)
  );

  csr_regs u_csr_regs (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_i         (cpu_req_i),
    .data_head_i   (data_head),
    .desc_head_i   (desc_head),
    .data_empty_i  (data_empty),
    .desc_empty_i  (desc_empty),
    .data_count_i  (data_count),
    .desc_count_i  (desc_count),
    .rsp_o         (cpu_rsp_o),
    .target_addr_o (target_addr),
    .data_pop_o    (data_pop),
    .desc_pop_o    (desc_pop)
  );

endmodule

/* hdl/sync_fifo.sv */
// Synchronous FIFO: circular buffer with read/write pointers and an occupancy counter
`timescale 1ns/1ps

module sync_fifo #(
  parameter type         payload_t = logic [7:0],
  parameter int unsigned DEPTH     = 4,
  parameter int unsigned PTR_W     = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  parameter int unsigned CNT_W     = $clog2(DEPTH + 1)
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             push_i,
  input  payload_t         data_i,
  input  logic             pop_i,
  output payload_t         head_o,
  output logic             empty_o,
  output logic             full_o,
  output logic [CNT_W-1:0] count_o
);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign count_o = count_q;
  assign head_o  = mem_q[rd_ptr_q];

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  no_push_when_full_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_o
  );

  no_pop_when_empty_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty_o
  );

endmodule

/* hdl/target_rx_fsm.sv */
// Target receive FSM: shifts in address and data bytes, drives ACK and feeds the RX queues
`timescale 1ns/1ps

module target_rx_fsm (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  i3c_pkg::bus_event_t event_i,
  input  logic [6:0]          target_addr_i,
  input  logic                data_full_i,
  input  logic                desc_full_i,
  output logic                sda_drive_o,
  output logic                data_push_o,
  output i3c_pkg::rx_data_t   data_o,
  output logic                desc_push_o,
  output i3c_pkg::rx_desc_t   desc_o
);

  import i3c_pkg::*;

  typedef enum logic [2:0] {
    IDLE, ADDR, ADDR_ACK, DATA, DATA_ACK, IGNORE
  } state_e;

  state_e     state_q;
  logic [3:0] bit_cnt_q;
  logic [7:0] shift_q;
  logic [6:0] addr_q;
  logic       rnw_q;
  logic [7:0] byte_cnt_q;
  logic       xfer_q;
  logic       byte_done;
  logic       addr_ack;
  logic       bus_edge;

  // Eighth bit has been sampled and SCL just went low
  assign byte_done = event_i.scl_fall && (bit_cnt_q == 4'd8);
  assign bus_edge  = event_i.start || event_i.stop;

  // Only writes to our own address, and only while a descriptor slot is free
  assign addr_ack = (shift_q[7:1] == target_addr_i) && !shift_q[0] && !desc_full_i;

  assign data_push_o = (state_q == DATA) && byte_done && !data_full_i;
  assign data_o      = shift_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      bit_cnt_q   <= '0;
      byte_cnt_q  <= '0;
      xfer_q      <= 1'b0;
      sda_drive_o <= 1'b1;
      desc_push_o <= 1'b0;
    end else if (bus_edge) begin
      // STOP or repeated START closes any open transfer
      state_q     <= event_i.start ? ADDR : IDLE;
      bit_cnt_q   <= '0;
      byte_cnt_q  <= '0;
      xfer_q      <= 1'b0;
      sda_drive_o <= 1'b1;
      desc_push_o <= xfer_q;
    end else begin
      desc_push_o <= 1'b0;
      if (event_i.scl_rise && (state_q == ADDR || state_q == DATA)) begin
        bit_cnt_q <= bit_cnt_q + 4'd1;
      end
      case (state_q)
        ADDR: begin
          if (byte_done) begin
            state_q     <= ADDR_ACK;
            sda_drive_o <= !addr_ack;
            xfer_q      <= addr_ack;
          end
        end
        ADDR_ACK: begin
          if (event_i.scl_fall) begin
            state_q     <= xfer_q ? DATA : IGNORE;
            bit_cnt_q   <= '0;
            sda_drive_o <= 1'b1;
          end
        end
        DATA: begin
          if (byte_done) begin
            state_q     <= DATA_ACK;
            // Full queue pushes back by NACKing the byte
            sda_drive_o <= data_full_i;
            if (!data_full_i) begin
              byte_cnt_q <= byte_cnt_q + 8'd1;
            end
          end
        end
        DATA_ACK: begin
          if (event_i.scl_fall) begin
            state_q     <= DATA;
            bit_cnt_q   <= '0;
            sda_drive_o <= 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (event_i.scl_rise) begin
      shift_q <= {shift_q[6:0], event_i.sda};
    end
    if (state_q == ADDR && byte_done) begin
      addr_q <= shift_q[7:1];
      rnw_q  <= shift_q[0];
    end
    if (bus_edge) begin
      desc_o <= '{addr: addr_q, rnw: rnw_q, byte_count: byte_cnt_q};
    end
  end

  sda_low_only_in_ack_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !sda_drive_o |-> (state_q == ADDR_ACK || state_q == DATA_ACK)
  );

endmodule

/* i3c_target.f */
+incdir+include
hdl/i3c_pkg.sv
hdl/i3c_phy.sv
hdl/bus_monitor.sv
hdl/target_rx_fsm.sv
hdl/sync_fifo.sv
hdl/csr_regs.sv
hdl/i3c_target.sv
test/tb_i3c_target.sv

/* include/i3c_settings.svh */
// I3C target receive path settings: queue depths, CPU bus widths and register map
`ifndef I3C_SETTINGS_SVH
`define I3C_SETTINGS_SVH

// Queue depths in entries
`define I3C_RX_DATA_DEPTH 8
`define I3C_RX_DESC_DEPTH 4

// CPU register interface
`define I3C_CSR_AW 4
`define I3C_CSR_DW 32

// Register word offsets
`define I3C_REG_TARGET_ADDR 0
`define I3C_REG_STATUS 1
`define I3C_REG_RX_DESC 2
`define I3C_REG_RX_DATA 3

// Static address the target answers to out of reset
`define I3C_TARGET_ADDR_RST 7'h2A

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the I3C target testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f i3c_target.f --top-module tb_i3c_target -o tb_i3c_target
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/tb_i3c_target)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
  exit 0
fi
exit 1

/* test/tb_i3c_target.sv */
// Testbench for the I3C target receive path: bus master model, reference model and CPU checks
`timescale 1ns/1ps
`include "i3c_settings.svh"

module tb_i3c_target;

  import i3c_pkg::*;

  localparam int CPU_TIMEOUT = 8;
  localparam logic [3:0] REG_TARGET_ADDR = 4'(`I3C_REG_TARGET_ADDR);
  localparam logic [3:0] REG_STATUS      = 4'(`I3C_REG_STATUS);
  localparam logic [3:0] REG_RX_DESC     = 4'(`I3C_REG_RX_DESC);
  localparam logic [3:0] REG_RX_DATA     = 4'(`I3C_REG_RX_DATA);

  logic        clk = 1'b0;
  logic        rst_n;
  logic        scl_tb;
  logic        sda_tb;
  logic        scl_dut;
  logic        sda_dut;
  logic        scl_line;
  logic        sda_line;
  cpuif_req_t  cpu_req;
  cpuif_rsp_t  cpu_rsp;

  // Expected state kept by the reference model
  logic [7:0]  exp_data_q[$];
  logic [15:0] exp_desc_q[$];
  logic [6:0]  cur_tgt;
  logic [7:0]  payload [16];
  logic [31:0] rng_state;
  logic [31:0] exp_rd_data;
  string       exp_rd_name;
  int          mismatches;
  int          timeouts;

  // Open-drain bus, either side can pull low
  assign scl_line = scl_tb & scl_dut;
  assign sda_line = sda_tb & sda_dut;

  i3c_target uut (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .i3c_scl_i (scl_line),
    .i3c_sda_i (sda_line),
    .i3c_scl_o (scl_dut),
    .i3c_sda_o (sda_dut),
    .cpu_req_i (cpu_req),
    .cpu_rsp_o (cpu_rsp)
  );

  initial begin
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Bit 0 is the address ACK, bit i+1 the ACK of data byte i
  function automatic logic [16:0] ref_transfer(input logic [6:0] tgt, input logic [6:0] addr,
                                               input logic rnw, input logic [7:0] bytes [16],
                                               input int nbytes, input int data_occ,
                                               input int desc_occ);
    logic [16:0] acks;
    logic        addr_ok;
    int          occ;
    int          cnt;
    acks    = '0;
    occ     = data_occ;
    cnt     = 0;
    addr_ok = (addr == tgt) && !rnw && (desc_occ < `I3C_RX_DESC_DEPTH);
    acks[0] = addr_ok;
    for (int i = 0; i < nbytes; i++) begin
      if (addr_ok && occ < `I3C_RX_DATA_DEPTH) begin
        acks[i+1] = 1'b1;
        exp_data_q.push_back(bytes[i]);
        occ++;
        cnt++;
      end
    end
    if (addr_ok) begin
      exp_desc_q.push_back({addr, rnw, 8'(cnt)});
    end
    return acks;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic hold(input int cycles);
    repeat (cycles) @(negedge clk);
  endtask

  task automatic fill_payload(input int n);
    for (int i = 0; i < n; i++) begin
      rng_state  = xorshift(rng_state);
      payload[i] = rng_state[7:0];
    end
  endtask

  // START from idle, or repeated START when SCL is already low
  task automatic bus_start();
    if (!scl_tb) begin
      hold(4);
      sda_tb = 1'b1;
      hold(4);
      scl_tb = 1'b1;
      hold(8);
    end
    sda_tb = 1'b0;
    hold(8);
    scl_tb = 1'b0;
  endtask

  task automatic bus_stop();
    hold(4);
    sda_tb = 1'b0;
    hold(4);
    scl_tb = 1'b1;
    hold(8);
    sda_tb = 1'b1;
    hold(8);
  endtask

  task automatic send_bit(input logic b);
    hold(4);
    sda_tb = b;
    hold(4);
    scl_tb = 1'b1;
    hold(8);
    scl_tb = 1'b0;
  endtask

  task automatic send_byte(input logic [7:0] b);
    for (int i = 7; i >= 0; i--) begin
      send_bit(b[i]);
    end
  endtask

  // Master releases SDA and samples the target in mid SCL high
  task automatic recv_ack(output logic acked);
    hold(4);
    sda_tb = 1'b1;
    hold(4);
    scl_tb = 1'b1;
    hold(4);
    acked = !sda_line;
    // Target never holds SCL low
    check("i3c_scl_o", 32'(scl_dut), 32'h1);
    hold(4);
    scl_tb = 1'b0;
  endtask

  task automatic bus_transfer(input logic [6:0] addr, input logic rnw, input int nbytes,
                              input logic stop_after);
    logic [16:0] exp_acks;
    logic [16:0] got_acks;
    logic        acked;
    exp_acks = ref_transfer(cur_tgt, addr, rnw, payload, nbytes,
                            exp_data_q.size(), exp_desc_q.size());
    got_acks = '0;
    bus_start();
    send_byte({addr, rnw});
    recv_ack(acked);
    got_acks[0] = acked;
    for (int i = 0; i < nbytes; i++) begin
      send_byte(payload[i]);
      recv_ack(acked);
      got_acks[i+1] = acked;
    end
    if (stop_after) begin
      bus_stop();
    end
    check("sda_ack", 32'(got_acks), 32'(exp_acks));
  endtask

  task automatic wait_ack(input logic is_wr);
    int waited;
    waited = 0;
    while (!(is_wr ? cpu_rsp.wr_ack : cpu_rsp.rd_ack) && waited < CPU_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!(is_wr ? cpu_rsp.wr_ack : cpu_rsp.rd_ack)) begin
      timeouts++;
      $display("timeout: CPU ack did not arrive within %0d cycles", CPU_TIMEOUT);
    end
    // Let the ack pulse pass before the next request
    @(negedge clk);
  endtask

  task automatic cpu_read(input logic [3:0] addr, input logic [31:0] exp, input string name);
    exp_rd_data     = exp;
    exp_rd_name     = name;
    cpu_req.req     = 1'b1;
    cpu_req.is_wr   = 1'b0;
    cpu_req.addr    = addr;
    cpu_req.wr_data = '0;
    @(negedge clk);
    cpu_req.req = 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic cpu_write(input logic [3:0] addr, input logic [31:0] data);
    cpu_req.req     = 1'b1;
    cpu_req.is_wr   = 1'b1;
    cpu_req.addr    = addr;
    cpu_req.wr_data = data;
    @(negedge clk);
    cpu_req.req = 1'b0;
    wait_ack(1'b1);
    if (addr == REG_TARGET_ADDR) begin
      cur_tgt = data[6:0];
    end
  endtask

  // Drain both queues through the CPU and expect an empty read at the end
  task automatic verify_queues();
    logic [31:0] status;
    status = 32'(exp_data_q.size()) | (32'(exp_desc_q.size()) << 8);
    cpu_read(REG_STATUS, status, "status");
    while (exp_data_q.size() > 0) begin
      cpu_read(REG_RX_DATA, 32'h8000_0000 | 32'(exp_data_q.pop_front()), "rx_data");
    end
    cpu_read(REG_RX_DATA, 32'h0, "rx_data");
    while (exp_desc_q.size() > 0) begin
      cpu_read(REG_RX_DESC, 32'h8000_0000 | 32'(exp_desc_q.pop_front()), "rx_desc");
    end
    cpu_read(REG_RX_DESC, 32'h0, "rx_desc");
  endtask

  // Read data checker, rd_data is valid with rd_ack
  always @(negedge clk) begin
    if (rst_n && cpu_rsp.rd_ack) begin
      check(exp_rd_name, cpu_rsp.rd_data, exp_rd_data);
    end
  end

  initial begin
    rst_n       = 1'b0;
    scl_tb      = 1'b1;
    sda_tb      = 1'b1;
    cpu_req     = '0;
    rng_state   = 32'd13;
    cur_tgt     = `I3C_TARGET_ADDR_RST;
    exp_rd_data = '0;
    exp_rd_name = "none";
    mismatches  = 0;
    timeouts    = 0;
    hold(8);
    rst_n = 1'b1;
    hold(2);

    // Bus released and no CPU response out of reset
    check("i3c_scl_o", 32'(scl_dut), 32'h1);
    check("i3c_sda_o", 32'(sda_dut), 32'h1);
    check("rd_ack", 32'(cpu_rsp.rd_ack), 32'h0);
    check("wr_ack", 32'(cpu_rsp.wr_ack), 32'h0);

    // Reset values
    cpu_read(REG_STATUS, 32'h0, "status");
    cpu_read(REG_TARGET_ADDR, 32'h2A, "target_addr");
    cpu_read(REG_RX_DATA, 32'h0, "rx_data");
    cpu_read(REG_RX_DESC, 32'h0, "rx_desc");

    // Write to own address
    fill_payload(4);
    bus_transfer(7'h2A, 1'b0, 4, 1'b1);
    verify_queues();

    // Foreign address and a read are both refused
    fill_payload(2);
    bus_transfer(7'h15, 1'b0, 2, 1'b1);
    bus_transfer(7'h2A, 1'b1, 0, 1'b1);
    verify_queues();

    // New target address
    cpu_write(REG_TARGET_ADDR, 32'h33);
    cpu_read(REG_TARGET_ADDR, 32'h33, "target_addr");
    fill_payload(3);
    bus_transfer(7'h2A, 1'b0, 3, 1'b1);
    bus_transfer(7'h33, 1'b0, 3, 1'b1);
    verify_queues();

    // Overflow of the data queue
    fill_payload(10);
    bus_transfer(7'h33, 1'b0, 10, 1'b1);
    verify_queues();

    // Two transfers joined by a repeated START
    fill_payload(3);
    bus_transfer(7'h33, 1'b0, 3, 1'b0);
    fill_payload(2);
    bus_transfer(7'h33, 1'b0, 2, 1'b1);
    verify_queues();

    $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
